// File: rtl/fftAccel.sv
`timescale 1ns/1ps
`default_nettype none

module fftAccel #(
    parameter int logN = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     startF,         // forward transform request
    input  logic                     startI,         // inverse transform request
    input  logic [fftPkg::tagW-1:0]  sigNum,
    input  logic                     inValid,
    output logic                     inReady,
    input  logic [fftPkg::dataW-1:0] inReal,
    input  logic [fftPkg::dataW-1:0] inImag,
    output logic                     outValid,
    input  logic                     outReady,
    output logic [fftPkg::dataW-1:0] outReal,
    output logic [fftPkg::dataW-1:0] outImag,
    output logic [fftPkg::tagW-1:0]  outTag,
    output logic                     calculating,
    output logic                     done
);
    import fftPkg::*;

    fftStateE               phase;
    logic                   isInverse;
    logic [$clog2(logN)-1:0] stageCount;
    logic [logN-2:0]        bflyCount;
    logic [logN-1:0]        ioCount, ioRev;
    logic [logN-1:0]        indexA, indexB, addrA;
    logic [logN-2:0]        twiddleIndex;
    logic [dataW-1:0]       twReal, twImag;
    logic [dataW-1:0]       rdRealA, rdImagA, rdRealB, rdImagB;
    logic [dataW-1:0]       bfRealA, bfImagA, bfRealB, bfImagB;
    logic [dataW-1:0]       wrRealA, wrImagA;
    logic                   weA, weB;

    ////////////////////////////////////////////////////////////////////////////
    // blocks

    fftControl #(.logN(logN)) u_fftControl (
        .clk(clk), .rst(rst), .startF(startF), .startI(startI), .sigNum(sigNum),
        .inValid(inValid), .outReady(outReady), .phase(phase), .inReady(inReady),
        .outValid(outValid), .calculating(calculating), .done(done),
        .isInverse(isInverse), .outTag(outTag), .stageCount(stageCount),
        .bflyCount(bflyCount), .ioCount(ioCount)
    );

    fftAddressGen #(.logN(logN)) u_fftAddressGen (
        .stageCount(stageCount), .bflyCount(bflyCount),
        .indexA(indexA), .indexB(indexB), .twiddleIndex(twiddleIndex)
    );

    fftTwiddleRom #(.logN(logN)) u_fftTwiddleRom (
        .twiddleIndex(twiddleIndex), .twReal(twReal), .twImag(twImag)
    );

    fftButterfly u_fftButterfly (
        .aReal(rdRealA), .aImag(rdImagA), .bReal(rdRealB), .bImag(rdImagB),
        .twReal(twReal), .twImag(twImag), .isInverse(isInverse),
        .aRealOut(bfRealA), .aImagOut(bfImagA), .bRealOut(bfRealB), .bImagOut(bfImagB)
    );

    fftRam #(.logN(logN)) u_fftRam (
        .clk(clk), .rst(rst), .weA(weA), .weB(weB), .addrA(addrA), .addrB(indexB),
        .wrRealA(wrRealA), .wrImagA(wrImagA), .wrRealB(bfRealB), .wrImagB(bfImagB),
        .rdRealA(rdRealA), .rdImagA(rdImagA), .rdRealB(rdRealB), .rdImagB(rdImagB)
    );

    ////////////////////////////////////////////////////////////////////////////
    // port A muxing by phase

    // loading in bit-reversed order leaves the results in natural order
    always_comb begin
        for (int i = 0; i < logN; i++)
            ioRev[i] = ioCount[logN-1-i];
    end

    always_comb begin
        case (phase)
            LOAD:    addrA = ioRev;
            UNLOAD:  addrA = ioCount;
            default: addrA = indexA;
        endcase
    end

    assign wrRealA = (phase == LOAD) ? inReal : bfRealA;
    assign wrImagA = (phase == LOAD) ? inImag : bfImagA;
    assign weA     = (inValid && inReady) || (phase == CALC);
    assign weB     = (phase == CALC);   // both butterfly results land on the same edge

    assign outReal = rdRealA;           // held while ioCount waits on outReady
    assign outImag = rdImagA;

endmodule

`default_nettype wire

// File: rtl/fftAddressGen.sv
`timescale 1ns/1ps
`default_nettype none

module fftAddressGen #(
    parameter int logN = 4
) (
    input  logic [$clog2(logN)-1:0] stageCount,
    input  logic [logN-2:0]         bflyCount,
    output logic [logN-1:0]         indexA,
    output logic [logN-1:0]         indexB,
    output logic [logN-2:0]         twiddleIndex
);

    logic [logN-1:0] span;          // distance between A and B
    logic [logN-1:0] lowMask;       // bits below the inserted zero
    logic [logN-1:0] bflyExt;
    logic [logN-2:0] twiddleLow;

    always_comb begin
        span    = logN'(1) << stageCount;
        lowMask = span - 1'b1;
        bflyExt = {1'b0, bflyCount};
    end

    // split the count at bit s and open a zero there
    assign indexA = ((bflyExt & ~lowMask) << 1) | (bflyExt & lowMask);
    assign indexB = indexA + span;

    // position within the group, stretched to the N-point twiddle grid
    assign twiddleLow   = bflyCount & lowMask[logN-2:0];
    assign twiddleIndex = twiddleLow << ((logN - 1) - stageCount);

endmodule

`default_nettype wire

// File: rtl/fftButterfly.sv
`timescale 1ns/1ps
`default_nettype none

module fftButterfly (
    input  logic signed [fftPkg::dataW-1:0] aReal,
    input  logic signed [fftPkg::dataW-1:0] aImag,
    input  logic signed [fftPkg::dataW-1:0] bReal,
    input  logic signed [fftPkg::dataW-1:0] bImag,
    input  logic signed [fftPkg::dataW-1:0] twReal,
    input  logic signed [fftPkg::dataW-1:0] twImag,
    input  logic                            isInverse,
    output logic signed [fftPkg::dataW-1:0] aRealOut,
    output logic signed [fftPkg::dataW-1:0] aImagOut,
    output logic signed [fftPkg::dataW-1:0] bRealOut,
    output logic signed [fftPkg::dataW-1:0] bImagOut
);
    import fftPkg::*;

    // one extra bit so that conjugating -1.0 does not wrap
    logic signed [dataW:0]   wReal;
    logic signed [dataW:0]   wImag;
    logic signed [prodW-1:0] prodRR, prodII, prodRI, prodIR;
    logic signed [sumW-1:0]  tReal, tImag;
    logic signed [sumW-1:0]  aRealExt, aImagExt;

    assign wReal = twReal;
    assign wImag = isInverse ? -twImag : twImag;    // conjugate twiddle for the inverse

    // t = B * W, each partial product scaled on its own
    assign prodRR = bReal * wReal;
    assign prodII = bImag * wImag;
    assign prodRI = bReal * wImag;
    assign prodIR = bImag * wReal;

    assign tReal = scaleProduct(prodRR) - scaleProduct(prodII);
    assign tImag = scaleProduct(prodRI) + scaleProduct(prodIR);

    assign aRealExt = aReal;
    assign aImagExt = aImag;

    ////////////////////////////////////////////////////////////////////////////
    // outputs, halved every stage

    assign aRealOut = halveSum(aRealExt + tReal);
    assign aImagOut = halveSum(aImagExt + tImag);
    assign bRealOut = halveSum(aRealExt - tReal);
    assign bImagOut = halveSum(aImagExt - tImag);

endmodule

`default_nettype wire

// File: rtl/fftControl.sv
`timescale 1ns/1ps
`default_nettype none

module fftControl #(
    parameter int logN = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    startF,
    input  logic                    startI,
    input  logic [fftPkg::tagW-1:0] sigNum,
    input  logic                    inValid,
    input  logic                    outReady,
    output fftPkg::fftStateE        phase,
    output logic                    inReady,
    output logic                    outValid,
    output logic                    calculating,
    output logic                    done,
    output logic                    isInverse,
    output logic [fftPkg::tagW-1:0] outTag,
    output logic [$clog2(logN)-1:0] stageCount,
    output logic [logN-2:0]         bflyCount,
    output logic [logN-1:0]         ioCount
);
    import fftPkg::*;

    localparam int stageW = $clog2(logN);

    fftStateE state;
    fftModeE  mode;
    logic     startReq;

    assign startReq = (state == IDLE) && (startF || startI);

    ////////////////////////////////////////////////////////////////////////////
    // state machine and counters

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            mode       <= MODE_FWD;
            ioCount    <= '0;
            stageCount <= '0;
            bflyCount  <= '0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: begin
                    if (startReq) begin
                        state   <= LOAD;
                        mode    <= startF ? MODE_FWD : MODE_INV;    // forward wins a tie
                        ioCount <= '0;
                    end
                end
                LOAD: begin
                    if (inValid) begin
                        ioCount <= ioCount + 1'b1;
                        if (&ioCount) begin                     // Nth beat taken
                            state      <= CALC;
                            stageCount <= '0;
                            bflyCount  <= '0;
                        end
                    end
                end
                CALC: begin
                    bflyCount <= bflyCount + 1'b1;              // one butterfly per cycle
                    if (&bflyCount) begin
                        stageCount <= stageCount + 1'b1;
                        if (stageCount == stageW'(logN - 1))
                            state <= UNLOAD;
                    end
                end
                UNLOAD: begin
                    if (outReady) begin
                        ioCount <= ioCount + 1'b1;
                        if (&ioCount) begin
                            state <= IDLE;
                            done  <= 1'b1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // tag only loads on an accepted start
    always_ff @(posedge clk) begin
        if (startReq)
            outTag <= sigNum;
    end

    assign phase       = state;
    assign inReady     = (state == LOAD);
    assign outValid    = (state == UNLOAD);
    assign calculating = (state == CALC);
    assign isInverse   = (mode == MODE_INV);

endmodule

`default_nettype wire

// File: rtl/fftPkg.sv
`default_nettype none

package fftPkg;

    localparam int dataW = 16;              // Q1.15 real or imaginary part
    localparam int tagW  = 18;              // host signal tag

    // widths used inside the butterfly
    localparam int prodW = 2 * dataW + 1;   // sample times widened twiddle
    localparam int sumW  = dataW + 3;       // A +/- t before halving

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        CALC,
        UNLOAD
    } fftStateE;

    typedef enum logic {
        MODE_FWD,
        MODE_INV
    } fftModeE;

    // Q2.30 product back to Q.15, truncated toward minus infinity
    function automatic logic signed [sumW-1:0] scaleProduct(input logic signed [prodW-1:0] p);
        logic signed [prodW-1:0] shifted;
        shifted = p >>> (dataW - 1);
        return shifted[sumW-1:0];
    endfunction

    // per-stage 1/2 scaling, arithmetic shift with truncation
    function automatic logic signed [dataW-1:0] halveSum(input logic signed [sumW-1:0] sum);
        return sum[dataW:1];
    endfunction

endpackage

`default_nettype wire

// File: rtl/fftRam.sv
`timescale 1ns/1ps
`default_nettype none

module fftRam #(
    parameter int logN = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     weA,
    input  logic                     weB,
    input  logic [logN-1:0]          addrA,
    input  logic [logN-1:0]          addrB,
    input  logic [fftPkg::dataW-1:0] wrRealA,
    input  logic [fftPkg::dataW-1:0] wrImagA,
    input  logic [fftPkg::dataW-1:0] wrRealB,
    input  logic [fftPkg::dataW-1:0] wrImagB,
    output logic [fftPkg::dataW-1:0] rdRealA,
    output logic [fftPkg::dataW-1:0] rdImagA,
    output logic [fftPkg::dataW-1:0] rdRealB,
    output logic [fftPkg::dataW-1:0] rdImagB
);
    import fftPkg::*;

    localparam int n = 1 << logN;

    logic [dataW-1:0] memReal [n];
    logic [dataW-1:0] memImag [n];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < n; i++) begin
                memReal[i] <= '0;
                memImag[i] <= '0;
            end
        end else begin
            if (weA) begin
                memReal[addrA] <= wrRealA;
                memImag[addrA] <= wrImagA;
            end
            if (weB) begin                  // A and B never collide in a butterfly
                memReal[addrB] <= wrRealB;
                memImag[addrB] <= wrImagB;
            end
        end
    end

    // asynchronous reads feed the butterfly in the same cycle
    assign rdRealA = memReal[addrA];
    assign rdImagA = memImag[addrA];
    assign rdRealB = memReal[addrB];
    assign rdImagB = memImag[addrB];

endmodule

`default_nettype wire

// File: rtl/fftTwiddleRom.sv
`timescale 1ns/1ps
`default_nettype none

module fftTwiddleRom #(
    parameter int logN = 4
) (
    input  logic        [logN-2:0]          twiddleIndex,
    output logic signed [fftPkg::dataW-1:0] twReal,
    output logic signed [fftPkg::dataW-1:0] twImag
);
    import fftPkg::*;

    localparam int  n         = 1 << logN;
    localparam real pi        = 3.14159265358979323846;
    localparam real fullScale = 2.0 ** (dataW - 1);

    logic signed [dataW-1:0] cosTab [n/2];
    logic signed [dataW-1:0] sinTab [n/2];     // already negated, W = cos - j*sin

    // round half away from zero, +1.0 clips to the largest positive code
    function automatic logic signed [dataW-1:0] toQ15(input real x);
        real scaled;
        scaled = x * fullScale;
        if (scaled > fullScale - 1.0)
            scaled = fullScale - 1.0;
        scaled = (scaled >= 0.0) ? scaled + 0.5 : scaled - 0.5;
        return dataW'($rtoi(scaled));
    endfunction

    for (genvar k = 0; k < n/2; k++) begin : gTable
        localparam real angle = 2.0 * pi * k / n;
        localparam logic signed [dataW-1:0] cosVal = toQ15($cos(angle));
        localparam logic signed [dataW-1:0] sinVal = toQ15(-$sin(angle));
        assign cosTab[k] = cosVal;
        assign sinTab[k] = sinVal;
    end

    assign twReal = cosTab[twiddleIndex];
    assign twImag = sinTab[twiddleIndex];

endmodule

`default_nettype wire

// File: sim.f
rtl/fftPkg.sv
rtl/fftTwiddleRom.sv
rtl/fftButterfly.sv
rtl/fftAddressGen.sv
rtl/fftRam.sv
rtl/fftControl.sv
rtl/fftAccel.sv
tests/fftAccelTb.sv

// File: sim.sh
#!/bin/sh
# build the FFT testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module fftAccelTb \
    && ./obj_dir/VfftAccelTb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -qF '*** FAILED ***' sim.log && { echo "simulation reported failure"; exit 1; }
grep -qF '*** PASSED ***' sim.log || { echo "no pass message in sim.log"; exit 1; }
exit 0

// File: tests/fftAccelTb.sv
`timescale 1ns/1ps
`default_nettype none

module fftAccelTb;
    import fftPkg::*;

    localparam int n          = 16;
    localparam int calcLength = 32;         // logN * N/2 butterflies
    localparam int waitLimit  = 200;
    localparam int beatLimit  = 2000;       // unload under heavy back-pressure

    logic             clk;
    logic             rst;
    logic             startF;
    logic             startI;
    logic [tagW-1:0]  sigNum;
    logic             inValid;
    logic             inReady;
    logic [dataW-1:0] inReal;
    logic [dataW-1:0] inImag;
    logic             outValid;
    logic             outReady;
    logic [dataW-1:0] outReal;
    logic [dataW-1:0] outImag;
    logic [tagW-1:0]  outTag;
    logic             calculating;
    logic             done;

    logic [dataW-1:0] stimReal [n];
    logic [dataW-1:0] stimImag [n];
    logic [dataW-1:0] expReal [n];
    logic [dataW-1:0] expImag [n];
    logic [3:0]       modeVal;              // 0 forward, 1 inverse
    logic [tagW-1:0]  tagVal;
    int               bpPct;                // chance of outReady low, in percent
    int               fd;
    int               transforms;
    int               mismatches;
    int               failures;
    int               doneSeen;
    bit               aborted;

    fftAccel #(.logN(4)) u_fftAccel (
        .clk(clk), .rst(rst), .startF(startF), .startI(startI), .sigNum(sigNum),
        .inValid(inValid), .inReady(inReady), .inReal(inReal), .inImag(inImag),
        .outValid(outValid), .outReady(outReady), .outReal(outReal), .outImag(outImag),
        .outTag(outTag), .calculating(calculating), .done(done)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (done)
            doneSeen++;                     // pulses counted where they are stable
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    task automatic checkEqual(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        assert (got == want) else begin
            mismatches++;
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic stopOnTimeout(input string what);
        failures++;
        aborted = 1'b1;
        $display("Timeout at time %0t: gave up waiting for %s", $time, what);
    endtask

    task automatic readTransform(output bit ok);
        int               code;
        logic [dataW-1:0] r0, r1, r2, r3;
        ok = 1'b0;
        code = $fscanf(fd, "%h %h %d", modeVal, tagVal, bpPct);
        if (code != 3)
            return;                         // end of the stim file
        for (int k = 0; k < n; k++) begin
            code = $fscanf(fd, "%h %h %h %h", r0, r1, r2, r3);
            if (code != 4) begin
                failures++;
                $display("The stim file ends inside transform %0d", transforms);
                return;
            end
            stimReal[k] = r0;
            stimImag[k] = r1;
            expReal[k]  = r2;
            expImag[k]  = r3;
        end
        ok = 1'b1;
    endtask

    task automatic startTransform;
        startF = (modeVal == 0);
        startI = (modeVal != 0);
        sigNum = tagVal;
        @(negedge clk);
        startF = 1'b0;
        startI = 1'b0;
        sigNum = ~tagVal;                   // the latched tag must not follow this
    endtask

    task automatic loadSamples;
        int waited;
        for (int k = 0; k < n; k++) begin
            waited = 0;
            while (!inReady && waited < waitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (!inReady) begin
                stopOnTimeout("inReady");
                return;
            end
            inValid = 1'b1;
            inReal  = stimReal[k];
            inImag  = stimImag[k];
            if (k == 5) begin               // opposite start in LOAD, ignored
                startF = (modeVal != 0);
                startI = (modeVal == 0);
            end
            @(negedge clk);
            startF = 1'b0;
            startI = 1'b0;
        end
        inValid = 1'b0;
    endtask

    task automatic countCalc;
        int waited;
        int cycles;
        waited = 0;
        cycles = 0;
        while (!calculating && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!calculating) begin
            stopOnTimeout("calculating");
            return;
        end
        while (calculating && cycles < waitLimit) begin
            cycles++;
            startF = (cycles == 10);        // restart attempt mid CALC
            startI = (cycles == 10);
            @(negedge clk);
        end
        startF = 1'b0;
        startI = 1'b0;
        checkEqual(cycles, calcLength, "length of calculating");
    endtask

    task automatic unloadResults;
        int               beat;
        int               waited;
        bit               held;
        logic [dataW-1:0] heldReal, heldImag;
        beat   = 0;
        waited = 0;
        held   = 1'b0;
        while (beat < n && waited < beatLimit) begin
            if (held) begin                 // stalled beat must not move
                checkEqual(outValid, 1, "outValid while stalled");
                checkEqual(outReal, heldReal, "outReal while stalled");
                checkEqual(outImag, heldImag, "outImag while stalled");
            end
            if (outValid) begin
                checkEqual(outReal, expReal[beat], $sformatf("outReal of bin %0d", beat));
                checkEqual(outImag, expImag[beat], $sformatf("outImag of bin %0d", beat));
                checkEqual(outTag, tagVal, $sformatf("outTag at bin %0d", beat));
                checkEqual(done, 0, "done before the last beat");
            end
            outReady = (int'($urandom % 100) >= bpPct);
            held     = outValid && !outReady;
            heldReal = outReal;
            heldImag = outImag;
            if (outValid && outReady)
                beat++;
            @(negedge clk);
            waited++;
        end
        outReady = 1'b0;
        if (beat < n)
            stopOnTimeout("the output beats");
    endtask

    task automatic waitForDone;
        int waited;
        waited = 0;
        while (!done && waited < waitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            stopOnTimeout("done");
            return;
        end
        checkEqual(waited, 0, "cycles from last beat to done");
        @(negedge clk);
        checkEqual(done, 0, "done one cycle after its pulse");
        checkEqual(doneSeen, transforms, "done pulse count");
    endtask

    task automatic runTransform;
        startTransform();
        loadSamples();
        if (aborted)
            return;
        countCalc();
        if (aborted)
            return;
        unloadResults();
        if (aborted)
            return;
        waitForDone();
    endtask

    task automatic finishRun;
        $display("Summary: %0d transforms, %0d mismatches, %0d other failures",
                 transforms, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        logic [8*128-1:0] line;
        int               code;
        bit               ok;
        clk        = 1'b0;
        rst        = 1'b1;
        startF     = 1'b0;
        startI     = 1'b0;
        sigNum     = '0;
        inValid    = 1'b0;
        inReal     = '0;
        inImag     = '0;
        outReady   = 1'b0;
        transforms = 0;
        mismatches = 0;
        failures   = 0;
        doneSeen   = 0;
        aborted    = 1'b0;
        code = $urandom(60515);
        fd = $fopen("tests/fftStim.txt", "r");
        if (fd == 0) begin
            failures++;
            aborted = 1'b1;
            $display("Could not open tests/fftStim.txt");
        end else begin
            code = $fgets(line, fd);        // two comment lines
            code = $fgets(line, fd);
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        checkEqual(inReady, 0, "inReady after reset");
        checkEqual(outValid, 0, "outValid after reset");
        checkEqual(calculating, 0, "calculating after reset");
        checkEqual(done, 0, "done after reset");
        ok = !aborted;
        while (ok && !aborted) begin
            readTransform(ok);
            if (ok) begin
                transforms++;
                runTransform();
            end
        end
        if (transforms == 0 && fd != 0) begin
            failures++;
            $display("The stim file holds no transform");
        end
        if (fd != 0)
            $fclose(fd);
        finishRun();
    end

endmodule

`default_nettype wire

// File: tests/fftStim.txt
# header: mode (0 forward, 1 inverse), tag in hex, output back-pressure in percent
# then 16 lines: inReal inImag expReal expImag in hex, sample k in and bin k out
0 0a5c3 0
4000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0000 0000 0400 0000
0 3f00d 40
2000 f000 04ff ffff
3000 1000 0527 fec6
0000 0000 04d4 fd95
0000 0000 0412 fc9b
0000 0000 0300 fc00
0000 0000 01c7 fbd8
0000 0000 0096 fc2b
0000 0000 ff9c fced
0000 0000 ff00 fe00
0000 0000 fed8 ff39
0000 0000 ff2b 006a
0000 0000 ffed 0164
0000 0000 0100 0200
0000 0000 0239 0228
0000 0000 036a 01d5
0000 0000 0464 0113
1 12345 60
1800 0800 ff80 02ff
e000 2800 feb2 020b
0000 0000 fe51 00da
0000 0000 fe6d ff9b
0000 0000 ff00 fe80
0000 0000 fff4 fdb1
0000 0000 0125 fd50
0000 0000 0264 fd6c
0000 0000 0380 fe00
0000 0000 044e fef5
0000 0000 04af 0026
0000 0000 0493 0165
0000 0000 0400 0280
0000 0000 030b 034e
0000 0000 01da 03af
0000 0000 009b 0393
